// File: board_ctrl.f
hdl/board_ctrl_pkg.sv
hdl/epb_wb_bridge.sv
hdl/wb_slot_decode.sv
hdl/misc_regs.sv
hdl/reset_ctrl.sv
hdl/selectmap_port.sv
hdl/rev_info.sv
hdl/board_ctrl_top.sv
sim/board_ctrl_tb.sv

// File: sim/board_ctrl_tb.sv
`timescale 1ns/1ns

module board_ctrl_tb;
  import board_ctrl_pkg::*;

  localparam logic [15:0] TB_DESIGN_ID = 16'hB5A7;
  localparam logic [7:0]  TB_REV_MAJOR = 8'h03;
  localparam logic [7:0]  TB_REV_MINOR = 8'h2C;
  localparam logic [15:0] TB_REV_RCS   = 16'h9E41;
  localparam int          WAIT_LIMIT   = 50;  // cycles allowed for one epb_rdy_o
  localparam int          SHIFT_LIMIT  = 100; // cycles allowed for a whole serial byte

  logic       clk_master = 1'b0;
  logic       sys_reset;
  logic       epb_reset_n_i, epb_cs_n_i, epb_oe_n_i, epb_we_n_i;
  logic [4:0] epb_addr_i;
  logic [7:0] epb_data_i, epb_data_o;
  logic       epb_data_oe_o, epb_rdy_o;
  logic       reset_debug_n_i, ppc_reset_n_o, ddr2_reset_n_o, geth_reset_n_o;
  logic       por_force_drive_o;
  logic [7:0] sys_config_i;
  logic [3:0] user_dip_i, config_dip_i;
  logic       flash_busy_n_i, ppc_syserr_i;
  logic [1:0] user_led_n_o, sys_led_n_o;
  logic [2:0] boot_conf_o;
  logic       eeprom_wp_o;
  logic       sm_cs_n_i, smap_prog_n_o, smap_cs_n_o, smap_rdwr_n_o;
  logic [2:0] smap_mode_o;
  logic       smap_din_o, smap_cclk_o, smap_done_i, smap_busy_i, smap_init_n_i;
  logic       smap_init_oe_o;

  int check_count    = 0;
  int mismatch_count = 0;
  int timeout_count  = 0;

  always #2 clk_master = ~clk_master;

  board_ctrl_top #(
    .DESIGN_ID (TB_DESIGN_ID), .REV_MAJOR (TB_REV_MAJOR),
    .REV_MINOR (TB_REV_MINOR), .REV_RCS (TB_REV_RCS), .BOOT_MODE (BOOT_DIP)
  ) board_ctrl_top_inst (.*);

  task automatic check_value(input string name, input logic [7:0] expected,
                             input logic [7:0] actual);
    check_count++;
    assert (actual === expected) else begin
      mismatch_count++;
      $display("MISMATCH at %0t ns: %s expected 0x%02h, got 0x%02h",
               $time, name, expected, actual);
    end
  endtask

  task automatic report_timeout(input string what);
    timeout_count++;
    $display("timeout at %0t ns: gave up waiting for %s", $time, what);
  endtask

  task automatic apply_reset();
    @(negedge clk_master);
    sys_reset = 1'b1;
    repeat (8) @(negedge clk_master);
    check_value("ddr2_reset_n_o", 8'h00, ddr2_reset_n_o); // board resets held low
    check_value("ppc_reset_n_o", 8'h00, ppc_reset_n_o);
    sys_reset = 1'b0;
    repeat (2) @(negedge clk_master); // bus reset is registered once more
  endtask

  // one host access with chip select held until ready is seen
  task automatic epb_cycle(input logic write, input logic [4:0] addr,
                           input logic [7:0] wdata, output logic [7:0] rdata);
    int waited;
    waited = 0;
    @(negedge clk_master);
    epb_addr_i = addr;
    epb_data_i = wdata;
    epb_we_n_i = !write;
    epb_oe_n_i = write;
    epb_cs_n_i = 1'b0;
    @(negedge clk_master);
    while (!epb_rdy_o && waited < WAIT_LIMIT) begin
      @(negedge clk_master);
      waited++;
    end
    if (!epb_rdy_o) report_timeout($sformatf("epb_rdy_o at address %0d", addr));
    rdata = epb_data_o;
    if (!write) check_value("epb_data_oe_o", 8'h01, epb_data_oe_o);
    epb_cs_n_i = 1'b1;
    epb_we_n_i = 1'b1;
    epb_oe_n_i = 1'b1;
  endtask

  task automatic epb_write(input logic [4:0] addr, input logic [7:0] wdata);
    logic [7:0] unused;
    epb_cycle(1'b1, addr, wdata, unused);
  endtask

  task automatic epb_read(input logic [4:0] addr, output logic [7:0] rdata);
    epb_cycle(1'b0, addr, 8'h00, rdata);
  endtask

  task automatic verify_reset_state();
    check_value("por_force_drive_o", 8'h00, por_force_drive_o);
    check_value("geth_reset_n_o", 8'h01, geth_reset_n_o);
    check_value("ppc_reset_n_o", 8'h01, ppc_reset_n_o);
    check_value("ddr2_reset_n_o", 8'h01, ddr2_reset_n_o);
    check_value("user_led_n_o", 8'h03, user_led_n_o);
    check_value("epb_rdy_o", 8'h00, epb_rdy_o);
    check_value("epb_data_oe_o", 8'h00, epb_data_oe_o);
    check_value("smap_prog_n_o", 8'h01, smap_prog_n_o);
    check_value("smap_cs_n_o", 8'h01, smap_cs_n_o);
    check_value("smap_rdwr_n_o", 8'h01, smap_rdwr_n_o);
  endtask

  task automatic read_revision();
    logic [7:0] rev_bytes [8];
    logic [7:0] rdata;
    rev_bytes = '{TB_DESIGN_ID[15:8], TB_DESIGN_ID[7:0], TB_REV_MAJOR, TB_REV_MINOR,
                  TB_REV_RCS[15:8], TB_REV_RCS[7:0], 8'h00, 8'h00};
    for (int i = 0; i < 8; i++) begin
      epb_read({2'b11, 3'(i)}, rdata);
      check_value($sformatf("rev byte %0d", i), rev_bytes[i], rdata);
    end
  endtask

  task automatic check_input_reads();
    logic [7:0] rdata;
    epb_read({2'b00, MISC_SYSCFG}, rdata);
    check_value("sys_config read", sys_config_i, rdata);
    epb_read({2'b00, MISC_DIP}, rdata);
    check_value("dip read", {user_dip_i, config_dip_i}, rdata);
    epb_read({2'b00, MISC_STATUS}, rdata);
    check_value("status read", {7'b0, flash_busy_n_i}, rdata);
  endtask

  task automatic exercise_misc_regs();
    logic [7:0] value;
    logic [7:0] rdata;
    repeat (4) begin
      value = 8'($urandom);
      epb_write({2'b00, MISC_SCRATCH}, value);
      epb_read({2'b00, MISC_SCRATCH}, rdata);
      check_value("scratch read", value, rdata);
      value = 8'($urandom) & 8'h03;
      epb_write({2'b00, MISC_LED}, value);
      epb_read({2'b00, MISC_LED}, rdata);
      check_value("led read", value, rdata);
      check_value("user_led_n_o", {6'b0, ~value[1:0]}, user_led_n_o);
    end
    repeat (3) begin
      @(negedge clk_master);
      sys_config_i   = 8'($urandom);
      user_dip_i     = 4'($urandom);
      config_dip_i   = 4'($urandom);
      flash_busy_n_i = 1'($urandom);
      check_input_reads();
      epb_write({2'b00, MISC_SYSCFG}, ~sys_config_i); // read-only register ignores this
      epb_write({2'b00, MISC_DIP}, 8'($urandom));
      epb_write({2'b00, MISC_STATUS}, 8'hFF);
      check_input_reads();
    end
  endtask

  task automatic sweep_boot_straps();
    logic [2:0] expected;
    for (int cfg = 0; cfg < 16; cfg++) begin
      for (int sc = 0; sc < 2; sc++) begin
        @(negedge clk_master);
        config_dip_i = 4'(cfg);
        sys_config_i = {6'($urandom), 1'(sc), 1'($urandom)};
        user_dip_i   = {1'(cfg ^ sc), 3'($urandom)};
        @(negedge clk_master);
        case (cfg % 4)
          0, 1:    expected = 3'b001; // config_dip bit1 low wins
          2:       expected = 3'b010;
          default: expected = (sc == 1) ? 3'b111 : 3'b010; // sys_config bit1 decides
        endcase
        check_value("boot_conf_o", {5'b0, expected}, boot_conf_o);
        check_value("eeprom_wp_o", {7'b0, !user_dip_i[3]}, eeprom_wp_o);
      end
    end
  endtask

  task automatic toggle_reset_controls();
    epb_write({2'b00, MISC_CTRL}, 8'h02);
    @(negedge clk_master);
    check_value("geth_reset_n_o", 8'h00, geth_reset_n_o);
    epb_write({2'b00, MISC_CTRL}, 8'h00);
    @(negedge clk_master);
    check_value("geth_reset_n_o", 8'h01, geth_reset_n_o);
    reset_debug_n_i = 1'b0; // debugger holds the ppc
    @(negedge clk_master);
    check_value("ppc_reset_n_o", 8'h00, ppc_reset_n_o);
    check_value("ddr2_reset_n_o", 8'h01, ddr2_reset_n_o);
    reset_debug_n_i = 1'b1;
    @(negedge clk_master);
    check_value("ppc_reset_n_o", 8'h01, ppc_reset_n_o);
    check_value("por_force_drive_o", 8'h00, por_force_drive_o);
    epb_write({2'b00, MISC_CTRL}, 8'h01); // rising por_force request
    @(negedge clk_master);
    check_value("por_force_drive_o", 8'h01, por_force_drive_o);
    epb_write({2'b00, MISC_CTRL}, 8'h00);
    @(negedge clk_master);
    check_value("por_force_drive_o", 8'h01, por_force_drive_o);
    apply_reset();
    check_value("por_force_drive_o", 8'h00, por_force_drive_o);
  endtask

  task automatic drive_selectmap();
    logic [7:0] value;
    logic [7:0] rdata;
    logic [7:0] captured;
    logic       prev_cclk;
    int         bits;
    int         waited;
    value = 8'($urandom) & 8'h7F;
    epb_write({2'b01, SMAP_CTRL}, value);
    check_value("smap_prog_n_o", {7'b0, value[0]}, smap_prog_n_o);
    check_value("smap_cs_n_o", {7'b0, value[1]}, smap_cs_n_o);
    check_value("smap_rdwr_n_o", {7'b0, value[2]}, smap_rdwr_n_o);
    check_value("smap_mode_o", {5'b0, value[5:3]}, smap_mode_o);
    check_value("smap_init_oe_o", {7'b0, value[6]}, smap_init_oe_o);
    epb_write({2'b01, SMAP_CTRL}, 8'h07); // back to idle pins
    @(negedge clk_master);
    {sm_cs_n_i, smap_init_n_i, smap_done_i, smap_busy_i} = 4'($urandom);
    ppc_syserr_i = 1'($urandom);
    epb_read({2'b01, SMAP_STATUS}, rdata);
    check_value("smap status",
                {3'b0, sm_cs_n_i, 1'b0, smap_init_n_i, smap_done_i, smap_busy_i}, rdata);
    check_value("sys_led_n_o", {6'b0, !smap_done_i, !ppc_syserr_i}, sys_led_n_o);
    value     = 8'($urandom);
    captured  = 8'h00;
    prev_cclk = 1'b0;
    bits      = 0;
    waited    = 0;
    fork
      begin
        epb_write({2'b01, SMAP_DATA}, value);
        epb_read({2'b01, SMAP_STATUS}, rdata);
        check_value("smap shifting", 8'h01, rdata[3]);
        epb_write({2'b01, SMAP_DATA}, ~value); // port still busy so this byte is lost
      end
      begin
        while (bits < 8 && waited < SHIFT_LIMIT) begin
          @(negedge clk_master);
          waited++;
          if (smap_cclk_o && !prev_cclk) begin
            captured = {captured[6:0], smap_din_o}; // msb arrives first
            bits++;
          end
          prev_cclk = smap_cclk_o;
        end
      end
    join
    if (bits < 8) report_timeout("eight rising edges of smap_cclk_o");
    check_value("smap serial byte", value, captured);
    epb_read({2'b01, SMAP_STATUS}, rdata);
    check_value("smap shifting", 8'h00, rdata[3]);
  endtask

  task automatic probe_reserved_slot();
    logic [7:0] scratch_val;
    logic [7:0] rdata;
    scratch_val = 8'($urandom);
    epb_write({2'b00, MISC_SCRATCH}, scratch_val);
    for (int i = 0; i < 8; i++) begin
      epb_read({2'b10, 3'(i)}, rdata);
      check_value($sformatf("reserved read %0d", i), 8'h00, rdata);
    end
    for (int i = 0; i < 8; i++) begin
      epb_write({2'b10, 3'(i)}, 8'($urandom));
    end
    epb_read({2'b00, MISC_SCRATCH}, rdata);
    check_value("scratch read", scratch_val, rdata);
    epb_read({2'b00, MISC_LED}, rdata);
    check_value("led read", 8'h00, rdata);
    epb_read({2'b11, 3'd0}, rdata);
    check_value("rev byte 0", TB_DESIGN_ID[15:8], rdata);
    check_value("smap_prog_n_o", 8'h01, smap_prog_n_o);
    check_value("smap_cs_n_o", 8'h01, smap_cs_n_o);
  endtask

  initial begin
    void'($urandom(70840));
    sys_reset       = 1'b1;
    epb_reset_n_i   = 1'b1;
    epb_cs_n_i      = 1'b1;
    epb_oe_n_i      = 1'b1;
    epb_we_n_i      = 1'b1;
    epb_addr_i      = 5'd0;
    epb_data_i      = 8'h00;
    reset_debug_n_i = 1'b1;
    sys_config_i    = 8'h00;
    user_dip_i      = 4'h0;
    config_dip_i    = 4'hF;
    flash_busy_n_i  = 1'b1;
    ppc_syserr_i    = 1'b0;
    sm_cs_n_i       = 1'b1;
    smap_done_i     = 1'b0;
    smap_busy_i     = 1'b0;
    smap_init_n_i   = 1'b1;
    apply_reset();
    verify_reset_state();
    read_revision();
    exercise_misc_regs();
    sweep_boot_straps();
    toggle_reset_controls();
    drive_selectmap();
    probe_reserved_slot();
    $display("checks: %0d, mismatches: %0d, timeouts: %0d",
             check_count, mismatch_count, timeout_count);
    if (mismatch_count == 0 && timeout_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // overall limit in case a wait loop itself stalls
  initial begin
    #200000;
    $display("simulation ran past its time limit without finishing");
    $display("Errors found");
    $finish;
  end

endmodule

// File: hdl/board_ctrl_top.sv
`timescale 1ns/1ns

module board_ctrl_top #(
  parameter logic [15:0]               DESIGN_ID = 16'h0001,
  parameter logic [7:0]                REV_MAJOR = 8'd1,
  parameter logic [7:0]                REV_MINOR = 8'd0,
  parameter logic [15:0]               REV_RCS   = 16'h0000,
  parameter board_ctrl_pkg::boot_mode_e BOOT_MODE = board_ctrl_pkg::BOOT_DIP
) (
  input  logic       clk_master,
  input  logic       sys_reset,
  input  logic       epb_reset_n_i,
  input  logic       epb_cs_n_i,
  input  logic       epb_oe_n_i,
  input  logic       epb_we_n_i,
  input  logic [4:0] epb_addr_i,
  input  logic [7:0] epb_data_i,
  output logic [7:0] epb_data_o,
  output logic       epb_data_oe_o,
  output logic       epb_rdy_o,
  input  logic       reset_debug_n_i,
  output logic       ppc_reset_n_o,
  output logic       ddr2_reset_n_o,
  output logic       geth_reset_n_o,
  output logic       por_force_drive_o,
  input  logic [7:0] sys_config_i,
  input  logic [3:0] user_dip_i,
  input  logic [3:0] config_dip_i,
  input  logic       flash_busy_n_i,
  input  logic       ppc_syserr_i,
  output logic [1:0] user_led_n_o,
  output logic [1:0] sys_led_n_o,
  output logic [2:0] boot_conf_o,
  output logic       eeprom_wp_o,
  input  logic       sm_cs_n_i,
  output logic       smap_prog_n_o,
  output logic       smap_cs_n_o,
  output logic       smap_rdwr_n_o,
  output logic [2:0] smap_mode_o,
  output logic       smap_din_o,
  output logic       smap_cclk_o,
  input  logic       smap_done_i,
  input  logic       smap_busy_i,
  input  logic       smap_init_n_i,
  output logic       smap_init_oe_o
);
  import board_ctrl_pkg::*;

  wb_req_t bus_req, misc_req, smap_req, rev_req;
  wb_rsp_t bus_rsp, misc_rsp, smap_rsp, rev_rsp;
  logic    bus_reset;
  logic    por_force;
  logic    geth_reset;

  epb_wb_bridge epb_wb_bridge_inst (
    .clk_master, .bus_reset_i (bus_reset),
    .epb_cs_n_i, .epb_oe_n_i, .epb_we_n_i, .epb_addr_i, .epb_data_i,
    .epb_data_o, .epb_data_oe_o, .epb_rdy_o,
    .req_o (bus_req), .rsp_i (bus_rsp)
  );

  wb_slot_decode wb_slot_decode_inst (
    .clk_master, .bus_reset_i (bus_reset), .req_i (bus_req),
    .misc_req_o (misc_req), .smap_req_o (smap_req), .rev_req_o (rev_req),
    .misc_rsp_i (misc_rsp), .smap_rsp_i (smap_rsp), .rev_rsp_i (rev_rsp),
    .rsp_o (bus_rsp)
  );

  misc_regs #(.BOOT_MODE (BOOT_MODE)) misc_regs_inst (
    .clk_master, .bus_reset_i (bus_reset), .req_i (misc_req), .rsp_o (misc_rsp),
    .sys_config_i, .user_dip_i, .config_dip_i, .flash_busy_n_i, .ppc_syserr_i,
    .smap_done_i, .por_force_o (por_force), .geth_reset_o (geth_reset),
    .user_led_n_o, .sys_led_n_o, .boot_conf_o, .eeprom_wp_o
  );

  reset_ctrl reset_ctrl_inst (
    .clk_master, .sys_reset, .epb_reset_n_i, .reset_debug_n_i,
    .por_force_i (por_force), .geth_reset_i (geth_reset), .bus_reset_o (bus_reset),
    .ppc_reset_n_o, .ddr2_reset_n_o, .geth_reset_n_o, .por_force_drive_o
  );

  selectmap_port selectmap_port_inst (
    .clk_master, .bus_reset_i (bus_reset), .req_i (smap_req), .rsp_o (smap_rsp),
    .sm_cs_n_i, .smap_done_i, .smap_busy_i, .smap_init_n_i,
    .smap_prog_n_o, .smap_cs_n_o, .smap_rdwr_n_o, .smap_mode_o, .smap_init_oe_o,
    .smap_din_o, .smap_cclk_o
  );

  rev_info #(
    .DESIGN_ID (DESIGN_ID), .REV_MAJOR (REV_MAJOR),
    .REV_MINOR (REV_MINOR), .REV_RCS (REV_RCS)
  ) rev_info_inst (
    .clk_master, .bus_reset_i (bus_reset), .req_i (rev_req), .rsp_o (rev_rsp)
  );

endmodule

// File: hdl/rev_info.sv
`timescale 1ns/1ns

module rev_info #(
  parameter logic [15:0] DESIGN_ID = 16'h0000,
  parameter logic [7:0]  REV_MAJOR = 8'h00,
  parameter logic [7:0]  REV_MINOR = 8'h00,
  parameter logic [15:0] REV_RCS   = 16'h0000
) (
  input  logic                    clk_master,
  input  logic                    bus_reset_i,
  input  board_ctrl_pkg::wb_req_t req_i,
  output board_ctrl_pkg::wb_rsp_t rsp_o
);

  logic ack_q;

  always_ff @(posedge clk_master) begin
    if (bus_reset_i) ack_q <= 1'b0;
    else             ack_q <= req_i.stb && !ack_q; // writes just complete
  end

  always_comb begin
    case (req_i.adr[2:0])
      3'd0:    rsp_o.dat = DESIGN_ID[15:8];
      3'd1:    rsp_o.dat = DESIGN_ID[7:0];
      3'd2:    rsp_o.dat = REV_MAJOR;
      3'd3:    rsp_o.dat = REV_MINOR;
      3'd4:    rsp_o.dat = REV_RCS[15:8];
      3'd5:    rsp_o.dat = REV_RCS[7:0];
      default: rsp_o.dat = 8'h00;
    endcase
    rsp_o.ack = ack_q;
  end

endmodule

// File: hdl/selectmap_port.sv
`timescale 1ns/1ns

module selectmap_port (
  input  logic                    clk_master,
  input  logic                    bus_reset_i,
  input  board_ctrl_pkg::wb_req_t req_i,
  output board_ctrl_pkg::wb_rsp_t rsp_o,
  input  logic                    sm_cs_n_i,
  input  logic                    smap_done_i,
  input  logic                    smap_busy_i,
  input  logic                    smap_init_n_i,
  output logic                    smap_prog_n_o,
  output logic                    smap_cs_n_o,
  output logic                    smap_rdwr_n_o,
  output logic [2:0]              smap_mode_o,
  output logic                    smap_init_oe_o,
  output logic                    smap_din_o,
  output logic                    smap_cclk_o
);
  import board_ctrl_pkg::*;

  logic [6:0] ctrl_q;     // {init_hold, mode, rdwr_n, cs_n, prog_n}
  logic [7:0] shift_q;
  logic [3:0] bit_cnt_q;  // bits already sent
  logic       phase_q;    // 0 low half of cclk, 1 high half
  logic       shifting_q;
  logic       ack_q;
  logic       wr_en;
  logic [7:0] rd_data;

  assign wr_en = req_i.stb && req_i.we && !ack_q;

  always_ff @(posedge clk_master) begin
    if (bus_reset_i) begin
      ctrl_q     <= 7'b000_0111; // prog_n, cs_n, rdwr_n idle high
      ack_q      <= 1'b0;
      shifting_q <= 1'b0;
      phase_q    <= 1'b0;
      bit_cnt_q  <= 4'd0;
    end else begin
      ack_q <= req_i.stb && !ack_q;
      if (wr_en && req_i.adr[2:0] == SMAP_CTRL) ctrl_q <= req_i.dat[6:0];
      if (shifting_q) begin
        phase_q <= !phase_q;
        if (phase_q) begin
          bit_cnt_q <= bit_cnt_q + 4'd1;
          if (bit_cnt_q == 4'd7) shifting_q <= 1'b0; // eighth bit done
        end
      end else if (wr_en && req_i.adr[2:0] == SMAP_DATA) begin
        shifting_q <= 1'b1; // writes while busy are dropped
        phase_q    <= 1'b0;
        bit_cnt_q  <= 4'd0;
      end
    end
  end

  always_ff @(posedge clk_master) begin
    if (!shifting_q && wr_en && req_i.adr[2:0] == SMAP_DATA) begin
      shift_q <= req_i.dat;
    end else if (shifting_q && phase_q) begin
      shift_q <= {shift_q[6:0], 1'b0}; // msb first
    end
  end

  always_comb begin
    rd_data = 8'h00;
    case (req_i.adr[2:0])
      SMAP_CTRL:   rd_data = {1'b0, ctrl_q};
      SMAP_STATUS: rd_data = {3'b0, sm_cs_n_i, shifting_q, smap_init_n_i, smap_done_i,
                              smap_busy_i};
      default:     rd_data = 8'h00;
    endcase
  end

  assign rsp_o.dat = rd_data;
  assign rsp_o.ack = ack_q;

  assign smap_prog_n_o  = ctrl_q[0];
  assign smap_cs_n_o    = ctrl_q[1];
  assign smap_rdwr_n_o  = ctrl_q[2];
  assign smap_mode_o    = ctrl_q[5:3];
  assign smap_init_oe_o = ctrl_q[6]; // hold init_n low on the target
  assign smap_din_o     = shift_q[7];
  assign smap_cclk_o    = shifting_q && phase_q;

  a_bit_cnt_range : assert property (
    @(posedge clk_master) disable iff (bus_reset_i) shifting_q |-> bit_cnt_q <= 4'd7
  );

endmodule

// File: hdl/reset_ctrl.sv
`timescale 1ns/1ns

module reset_ctrl (
  input  logic clk_master,
  input  logic sys_reset,
  input  logic epb_reset_n_i,
  input  logic reset_debug_n_i,
  input  logic por_force_i,
  input  logic geth_reset_i,
  output logic bus_reset_o,
  output logic ppc_reset_n_o,
  output logic ddr2_reset_n_o,
  output logic geth_reset_n_o,
  output logic por_force_drive_o
);

  logic bus_reset_q;
  logic ppc_reset_n_q;
  logic ddr2_reset_n_q;
  logic geth_reset_n_q;
  logic por_prev_q;
  logic por_drive_q;

  // board resets, one edge behind their inputs
  always_ff @(posedge clk_master) begin
    bus_reset_q    <= sys_reset || !epb_reset_n_i;
    ppc_reset_n_q  <= reset_debug_n_i && !sys_reset; // debugger can hold the ppc
    ddr2_reset_n_q <= !sys_reset;
    geth_reset_n_q <= !sys_reset && !geth_reset_i;
    por_prev_q     <= por_force_i;
  end

  // por force latches on a rising request and only sys_reset clears it
  always_ff @(posedge clk_master) begin
    if (sys_reset) begin
      por_drive_q <= 1'b0;
    end else if (por_force_i && !por_prev_q) begin
      por_drive_q <= 1'b1;
    end
  end

  assign bus_reset_o       = bus_reset_q;
  assign ppc_reset_n_o     = ppc_reset_n_q;
  assign ddr2_reset_n_o    = ddr2_reset_n_q;
  assign geth_reset_n_o    = geth_reset_n_q;
  assign por_force_drive_o = por_drive_q; // enables the open drain pull-down

endmodule

// File: hdl/misc_regs.sv
`timescale 1ns/1ns

module misc_regs #(
  parameter board_ctrl_pkg::boot_mode_e BOOT_MODE = board_ctrl_pkg::BOOT_DIP
) (
  input  logic                    clk_master,
  input  logic                    bus_reset_i,
  input  board_ctrl_pkg::wb_req_t req_i,
  output board_ctrl_pkg::wb_rsp_t rsp_o,
  input  logic [7:0]              sys_config_i,
  input  logic [3:0]              user_dip_i,
  input  logic [3:0]              config_dip_i,
  input  logic                    flash_busy_n_i,
  input  logic                    ppc_syserr_i,
  input  logic                    smap_done_i,
  output logic                    por_force_o,
  output logic                    geth_reset_o,
  output logic [1:0]              user_led_n_o,
  output logic [1:0]              sys_led_n_o,
  output logic [2:0]              boot_conf_o,
  output logic                    eeprom_wp_o
);
  import board_ctrl_pkg::*;

  logic [1:0] ctrl_q;
  logic [1:0] led_q;
  logic [7:0] scratch_q;
  logic [1:0] sys_led_n_q;
  logic       ack_q;
  logic       wr_en;
  logic [7:0] rd_data;

  assign wr_en = req_i.stb && req_i.we && !ack_q; // first cycle of a write only

  always_ff @(posedge clk_master) begin
    if (bus_reset_i) begin
      ctrl_q <= 2'b00;
      led_q  <= 2'b00;
      ack_q  <= 1'b0;
    end else begin
      ack_q <= req_i.stb && !ack_q;
      if (wr_en && req_i.adr[2:0] == MISC_CTRL) ctrl_q <= req_i.dat[1:0];
      if (wr_en && req_i.adr[2:0] == MISC_LED)  led_q  <= req_i.dat[1:0];
    end
  end

  always_ff @(posedge clk_master) begin
    if (wr_en && req_i.adr[2:0] == MISC_SCRATCH) scratch_q <= req_i.dat;
    sys_led_n_q <= ~{smap_done_i, ppc_syserr_i};
  end

  always_comb begin
    rd_data = 8'h00; // unused addresses
    case (req_i.adr[2:0])
      MISC_CTRL:    rd_data = {6'b0, ctrl_q};
      MISC_LED:     rd_data = {6'b0, led_q};
      MISC_SYSCFG:  rd_data = sys_config_i;
      MISC_DIP:     rd_data = {user_dip_i, config_dip_i};
      MISC_STATUS:  rd_data = {7'b0, flash_busy_n_i};
      MISC_SCRATCH: rd_data = scratch_q;
      default:      rd_data = 8'h00;
    endcase
  end

  assign rsp_o.dat = rd_data;
  assign rsp_o.ack = ack_q;

  // boot straps for the processor
  always_comb begin
    case (BOOT_MODE)
      BOOT_EEPROM: boot_conf_o = 3'b111; // i2c eeprom boot
      BOOT_FAST:   boot_conf_o = 3'b010;
      default: begin
        if (!config_dip_i[1])     boot_conf_o = 3'b001;
        else if (!config_dip_i[0]) boot_conf_o = 3'b010;
        else if (sys_config_i[1])  boot_conf_o = 3'b111;
        else                       boot_conf_o = 3'b010;
      end
    endcase
  end

  assign por_force_o  = ctrl_q[0];
  assign geth_reset_o = ctrl_q[1];
  assign user_led_n_o = ~led_q;
  assign sys_led_n_o  = sys_led_n_q;
  assign eeprom_wp_o  = !user_dip_i[3]; // dip 3 up unprotects eeproms

endmodule

// File: hdl/wb_slot_decode.sv
`timescale 1ns/1ns

module wb_slot_decode (
  input  logic                    clk_master,
  input  logic                    bus_reset_i,
  input  board_ctrl_pkg::wb_req_t req_i,
  output board_ctrl_pkg::wb_req_t misc_req_o,
  output board_ctrl_pkg::wb_req_t smap_req_o,
  output board_ctrl_pkg::wb_req_t rev_req_o,
  input  board_ctrl_pkg::wb_rsp_t misc_rsp_i,
  input  board_ctrl_pkg::wb_rsp_t smap_rsp_i,
  input  board_ctrl_pkg::wb_rsp_t rev_rsp_i,
  output board_ctrl_pkg::wb_rsp_t rsp_o
);
  import board_ctrl_pkg::*;

  slot_e slot;
  logic  rsvd_stb;
  logic  rsvd_ack_q;

  assign slot     = slot_e'(req_i.adr[4:3]);
  assign rsvd_stb = req_i.stb && (slot == SLOT_RSVD);

  always_comb begin
    misc_req_o     = req_i;
    smap_req_o     = req_i;
    rev_req_o      = req_i;
    misc_req_o.stb = req_i.stb && (slot == SLOT_MISC);
    smap_req_o.stb = req_i.stb && (slot == SLOT_SMAP);
    rev_req_o.stb  = req_i.stb && (slot == SLOT_REV);
  end

  // empty slot still has to complete the cycle
  always_ff @(posedge clk_master) begin
    if (bus_reset_i) begin
      rsvd_ack_q <= 1'b0;
    end else begin
      rsvd_ack_q <= rsvd_stb && !rsvd_ack_q;
    end
  end

  always_comb begin
    case (slot)
      SLOT_MISC: rsp_o.dat = misc_rsp_i.dat;
      SLOT_SMAP: rsp_o.dat = smap_rsp_i.dat;
      SLOT_REV:  rsp_o.dat = rev_rsp_i.dat;
      default:   rsp_o.dat = 8'h00; // reserved reads zero
    endcase
    rsp_o.ack = misc_rsp_i.ack | smap_rsp_i.ack | rsvd_ack_q | rev_rsp_i.ack;
  end

  a_one_ack : assert property (
    @(posedge clk_master) disable iff (bus_reset_i)
      $onehot0({misc_rsp_i.ack, smap_rsp_i.ack, rsvd_ack_q, rev_rsp_i.ack})
  );

endmodule

// File: hdl/epb_wb_bridge.sv
`timescale 1ns/1ns

module epb_wb_bridge (
  input  logic                   clk_master,
  input  logic                   bus_reset_i,
  input  logic                   epb_cs_n_i,
  input  logic                   epb_oe_n_i,
  input  logic                   epb_we_n_i,
  input  logic [4:0]             epb_addr_i,
  input  logic [7:0]             epb_data_i,
  output logic [7:0]             epb_data_o,
  output logic                   epb_data_oe_o,
  output logic                   epb_rdy_o,
  output board_ctrl_pkg::wb_req_t req_o,
  input  board_ctrl_pkg::wb_rsp_t rsp_i
);
  import board_ctrl_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT_ACK,
    ST_WAIT_REL
  } state_e;

  state_e     state_q;
  logic       stb_q;
  logic       we_q;
  logic [4:0] adr_q;
  logic [7:0] wdat_q;
  logic [7:0] rdat_q;
  logic       rdy_q;
  logic       data_oe_q;
  logic       start;

  // host asks for a cycle: chip select plus a read or write strobe
  assign start = !epb_cs_n_i && (!epb_oe_n_i || !epb_we_n_i);

  always_ff @(posedge clk_master) begin
    if (bus_reset_i) begin
      state_q   <= ST_IDLE;
      stb_q     <= 1'b0;
      rdy_q     <= 1'b0;
      data_oe_q <= 1'b0;
    end else begin
      rdy_q <= 1'b0; // one cycle pulse only
      case (state_q)
        ST_IDLE: begin
          if (start) begin
            stb_q   <= 1'b1;
            state_q <= ST_WAIT_ACK;
          end
        end
        ST_WAIT_ACK: begin
          if (rsp_i.ack) begin
            stb_q     <= 1'b0;
            rdy_q     <= 1'b1;
            data_oe_q <= !we_q; // only drive the bus on reads
            state_q   <= ST_WAIT_REL;
          end
        end
        default: begin
          // no new cycle until the host lets go of chip select
          if (epb_cs_n_i) begin
            data_oe_q <= 1'b0;
            state_q   <= ST_IDLE;
          end
        end
      endcase
    end
  end

  // address, direction and write data, captured at the start
  always_ff @(posedge clk_master) begin
    if (state_q == ST_IDLE && start) begin
      we_q   <= !epb_we_n_i;
      adr_q  <= epb_addr_i;
      wdat_q <= epb_data_i;
    end
    if (state_q == ST_WAIT_ACK && rsp_i.ack) begin
      rdat_q <= rsp_i.dat; // held until cs_n rises
    end
  end

  assign req_o.stb = stb_q;
  assign req_o.we  = we_q;
  assign req_o.adr = adr_q;
  assign req_o.dat = wdat_q;

  assign epb_data_o    = rdat_q;
  assign epb_data_oe_o = data_oe_q;
  assign epb_rdy_o     = rdy_q;

  // slaves may only answer a cycle that is still open
  a_ack_needs_stb : assert property (
    @(posedge clk_master) disable iff (bus_reset_i) rsp_i.ack |-> stb_q
  );

endmodule

// File: hdl/board_ctrl_pkg.sv
package board_ctrl_pkg;

  // single-beat request from the EPB bridge
  typedef struct packed {
    logic       stb;
    logic       we;
    logic [4:0] adr;
    logic [7:0] dat;
  } wb_req_t;

  // response from one slot
  typedef struct packed {
    logic [7:0] dat;
    logic       ack;
  } wb_rsp_t;

  // address bits 4:3 select the slot
  typedef enum logic [1:0] {
    SLOT_MISC = 2'd0,
    SLOT_SMAP = 2'd1,
    SLOT_RSVD = 2'd2,
    SLOT_REV  = 2'd3
  } slot_e;

  // misc register block, slot 0
  localparam logic [2:0] MISC_CTRL    = 3'd0; // bit0 por_force, bit1 geth_reset
  localparam logic [2:0] MISC_LED     = 3'd1; // user leds, active high here
  localparam logic [2:0] MISC_SYSCFG  = 3'd2; // read only
  localparam logic [2:0] MISC_DIP     = 3'd3; // read only, {user_dip, config_dip}
  localparam logic [2:0] MISC_STATUS  = 3'd4; // read only, bit0 flash_busy_n
  localparam logic [2:0] MISC_SCRATCH = 3'd5;

  // selectmap port, slot 1
  localparam logic [2:0] SMAP_CTRL   = 3'd0; // prog_n, cs_n, rdwr_n, mode, init_hold
  localparam logic [2:0] SMAP_DATA   = 3'd1; // write only
  localparam logic [2:0] SMAP_STATUS = 3'd2;

  // where the boot straps come from
  typedef enum logic [1:0] {
    BOOT_DIP    = 2'd0,
    BOOT_EEPROM = 2'd1,
    BOOT_FAST   = 2'd2
  } boot_mode_e;

endpackage
